//--- hw/gp_cmd_pkg.sv
`default_nettype none

package gp_cmd_pkg;

    localparam int CMD_WORD_WIDTH = 32;

    // opcode in the top byte of the first word of a command
    localparam int OPCODE_LSB   = 24;
    localparam int OPCODE_WIDTH = 8;

    // color in the low bits of the first word
    localparam int COLOR_WIDTH = 24;

    // point word layout, each field COORD_WIDTH wide
    localparam int POINT_X_LSB = 16;
    localparam int POINT_Y_LSB = 0;

    typedef enum logic [OPCODE_WIDTH-1:0] {
        OP_END  = 8'h00,
        OP_LINE = 8'h01,
        OP_FILL = 8'h02
    } cmd_opcode_e;

    typedef enum logic [2:0] {
        IDLE,
        DECODE,
        LINE_X0,
        LINE_Y0,
        LINE_X1,
        LINE_Y1,
        FILL_WAIT
    } dec_state_e;

endpackage

`default_nettype wire

//--- hw/gp_mem_pkg.sv
`default_nettype none

package gp_mem_pkg;

    // one read beat from the DRAM controller
    localparam int BEAT_WIDTH = 128;

    // a command line is two beats, 32 bytes
    localparam int LINE_WIDTH = 256;

    // address FIFO entry
    localparam int DRAM_ADDR_WIDTH = 31;

    // byte address bits 27..5 name the line
    localparam int LINE_TAG_WIDTH = 23;

    // byte address bits 4..2 pick a word in the line
    localparam int WORD_SEL_WIDTH = 3;

    typedef enum logic [1:0] {
        F_IDLE,
        F_BEAT0,
        F_BEAT1
    } fetch_state_e;

endpackage

`default_nettype wire

//--- hw/line_fill_if.sv
`timescale 1ns/1ps
`default_nettype none

// line refill path between the command line buffer and the DRAM fetcher
interface line_fill_if
    import gp_mem_pkg::*;
();

    logic                      fill_req;
    logic [LINE_TAG_WIDTH-1:0] fill_tag;
    logic                      fill_valid;
    // word 0 sits in the top 32 bits
    logic [LINE_WIDTH-1:0]     fill_line;

    modport buffer (
        output fill_req,
        output fill_tag,
        input  fill_valid,
        input  fill_line
    );

    modport fetcher (
        input  fill_req,
        input  fill_tag,
        output fill_valid,
        output fill_line
    );

endinterface

`default_nettype wire

//--- hw/cmd_word_if.sv
`timescale 1ns/1ps
`default_nettype none

// command word lookup between the decoder and the line buffer
interface cmd_word_if
    import gp_cmd_pkg::*;
();

    // byte address of the current command word
    logic [CMD_WORD_WIDTH-1:0] word_addr;
    logic                      restart;
    logic                      hit;
    logic [CMD_WORD_WIDTH-1:0] word;

    modport decoder (
        output word_addr,
        output restart,
        input  hit,
        input  word
    );

    modport buffer (
        input  word_addr,
        input  restart,
        output hit,
        output word
    );

endinterface

`default_nettype wire

//--- hw/dram_line_fetcher.sv
`timescale 1ns/1ps
`default_nettype none

module dram_line_fetcher
    import gp_mem_pkg::*;
(
    input  wire logic                       clk,
    input  wire logic                       rst,
    line_fill_if.fetcher                    fill,
    input  wire logic                       af_full,
    output logic                            af_wr_en,
    output logic [DRAM_ADDR_WIDTH-1:0]      af_addr_din,
    input  wire logic                       rdf_valid,
    input  wire logic [BEAT_WIDTH-1:0]      rdf_dout,
    output logic                            rdf_rd_en
);

    localparam int BEAT_WORDS = 4;
    localparam int WORD_BITS  = BEAT_WIDTH / BEAT_WORDS;

    fetch_state_e state;
    fetch_state_e next_state;

    // first half of the line, already in line order
    logic [BEAT_WIDTH-1:0] beat0_q;
    logic [BEAT_WIDTH-1:0] beat_ordered;

    // DRAM puts the lowest word in the low bits, the line wants it on top
    function automatic logic [BEAT_WIDTH-1:0] to_line_order(
        input logic [BEAT_WIDTH-1:0] beat
    );
        logic [BEAT_WIDTH-1:0] swapped;
        for (int i = 0; i < BEAT_WORDS; i++) begin
            swapped[(BEAT_WORDS - 1 - i) * WORD_BITS +: WORD_BITS] =
                beat[i * WORD_BITS +: WORD_BITS];
        end
        return swapped;
    endfunction

    assign beat_ordered = to_line_order(rdf_dout);

    // tag lands at bits 24..2, upper bits zero
    assign af_addr_din = DRAM_ADDR_WIDTH'({fill.fill_tag, 2'b00});

    // second beat goes straight through in the cycle it is taken
    assign fill.fill_line = {beat0_q, beat_ordered};

    always_comb begin
        next_state      = state;
        af_wr_en        = 1'b0;
        rdf_rd_en       = 1'b0;
        fill.fill_valid = 1'b0;
        case (state)
            F_IDLE: begin
                af_wr_en = fill.fill_req;
                if (fill.fill_req && !af_full) begin
                    next_state = F_BEAT0;
                end
            end
            F_BEAT0: begin
                rdf_rd_en = 1'b1;
                if (rdf_valid) begin
                    next_state = F_BEAT1;
                end
            end
            F_BEAT1: begin
                rdf_rd_en = 1'b1;
                if (rdf_valid) begin
                    fill.fill_valid = 1'b1;
                    next_state      = F_IDLE;
                end
            end
            default: next_state = F_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= F_IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_ff @(posedge clk) begin
        if (state == F_BEAT0 && rdf_valid) begin
            beat0_q <= beat_ordered;
        end
    end

endmodule

`default_nettype wire

//--- hw/command_line_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module command_line_buffer
    import gp_cmd_pkg::*;
    import gp_mem_pkg::*;
(
    input  wire logic   clk,
    input  wire logic   rst,
    line_fill_if.buffer fill,
    cmd_word_if.buffer  cmd
);

    localparam int LINE_WORDS = LINE_WIDTH / CMD_WORD_WIDTH;
    localparam int SEL_LSB    = 2;
    localparam int TAG_LSB    = SEL_LSB + WORD_SEL_WIDTH;

    logic [LINE_WIDTH-1:0]     line_q;
    logic [LINE_TAG_WIDTH-1:0] tag_q;
    logic                      valid_q;
    // no fills until the first list has started
    logic                      armed_q;
    // fill in flight was asked for before a restart
    logic                      stale_q;

    logic [LINE_TAG_WIDTH-1:0] cur_tag;
    logic [WORD_SEL_WIDTH-1:0] cur_sel;
    logic                      miss;

    assign cur_tag = cmd.word_addr[TAG_LSB +: LINE_TAG_WIDTH];
    assign cur_sel = cmd.word_addr[SEL_LSB +: WORD_SEL_WIDTH];

    assign cmd.hit  = valid_q && (tag_q == cur_tag);
    assign cmd.word = line_q[(LINE_WORDS - 1 - int'(cur_sel)) * CMD_WORD_WIDTH +: CMD_WORD_WIDTH];

    assign miss = armed_q && !cmd.hit;

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q       <= 1'b0;
            armed_q       <= 1'b0;
            stale_q       <= 1'b0;
            fill.fill_req <= 1'b0;
        end else begin
            if (cmd.restart) begin
                armed_q <= 1'b1;
            end
            // restart wins over a returning line, which may hold old memory
            if (cmd.restart) begin
                valid_q <= 1'b0;
            end else if (fill.fill_valid && !stale_q) begin
                valid_q <= 1'b1;
            end
            if (fill.fill_valid) begin
                stale_q <= 1'b0;
            end else if (cmd.restart && fill.fill_req) begin
                stale_q <= 1'b1;
            end
            if (fill.fill_valid) begin
                fill.fill_req <= 1'b0;
            end else if (miss && !fill.fill_req) begin
                fill.fill_req <= 1'b1;
            end
        end
    end

    // request tag held steady for the whole fill
    always_ff @(posedge clk) begin
        if (miss && !fill.fill_req && !fill.fill_valid) begin
            fill.fill_tag <= cur_tag;
        end
    end

    always_ff @(posedge clk) begin
        if (fill.fill_valid) begin
            line_q <= fill.fill_line;
            tag_q  <= fill.fill_tag;
        end
    end

endmodule

`default_nettype wire

//--- hw/command_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module command_decoder
    import gp_cmd_pkg::*;
#(
    parameter int COORD_WIDTH = 10
) (
    input  wire logic                      clk,
    input  wire logic                      rst,
    cmd_word_if.decoder                    cmd,

    // host
    input  wire logic                      gp_valid,
    input  wire logic [CMD_WORD_WIDTH-1:0] gp_code,
    input  wire logic [31:0]               gp_frame,

    // line engine
    input  wire logic                      le_ready,
    output logic [COLOR_WIDTH-1:0]         le_color,
    output logic [COORD_WIDTH-1:0]         le_point,
    output logic                           le_color_valid,
    output logic                           le_x0_valid,
    output logic                           le_y0_valid,
    output logic                           le_x1_valid,
    output logic                           le_y1_valid,
    output logic                           le_trigger,
    output logic [31:0]                    le_frame,

    // frame filler
    input  wire logic                      ff_ready,
    output logic                           ff_valid,
    output logic [COLOR_WIDTH-1:0]         ff_color,
    output logic [31:0]                    ff_frame
);

    dec_state_e state;
    dec_state_e next_state;

    logic [CMD_WORD_WIDTH-1:0] ptr_q;
    logic [CMD_WORD_WIDTH-1:0] next_ptr;
    logic [31:0]               frame_q;
    cmd_opcode_e               opcode;

    assign opcode = cmd_opcode_e'(cmd.word[OPCODE_LSB +: OPCODE_WIDTH]);

    assign cmd.word_addr = ptr_q;
    // same edge loads the pointer and drops the cached line
    assign cmd.restart   = gp_valid;

    assign le_color = cmd.word[COLOR_WIDTH-1:0];
    assign ff_color = cmd.word[COLOR_WIDTH-1:0];
    assign le_point = (le_x0_valid || le_x1_valid) ?
                      cmd.word[POINT_X_LSB +: COORD_WIDTH] :
                      cmd.word[POINT_Y_LSB +: COORD_WIDTH];

    assign le_frame = frame_q;
    assign ff_frame = frame_q;

    always_comb begin
        next_state     = state;
        next_ptr       = ptr_q;
        le_color_valid = 1'b0;
        le_x0_valid    = 1'b0;
        le_y0_valid    = 1'b0;
        le_x1_valid    = 1'b0;
        le_y1_valid    = 1'b0;
        le_trigger     = 1'b0;
        ff_valid       = 1'b0;
        if (gp_valid) begin
            next_state = DECODE;
            next_ptr   = gp_code;
        end else if (state == FILL_WAIT) begin
            // filler busy, word not needed here
            if (ff_ready) begin
                next_state = DECODE;
            end
        end else if (cmd.hit) begin
            case (state)
                DECODE: begin
                    case (opcode)
                        OP_LINE: begin
                            if (le_ready) begin
                                le_color_valid = 1'b1;
                                next_ptr       = ptr_q + 4;
                                next_state     = LINE_X0;
                            end
                        end
                        OP_FILL: begin
                            if (ff_ready) begin
                                ff_valid   = 1'b1;
                                next_ptr   = ptr_q + 4;
                                next_state = FILL_WAIT;
                            end
                        end
                        OP_END:  next_state = IDLE;
                        // unknown opcodes stop the list too
                        default: next_state = IDLE;
                    endcase
                end
                LINE_X0: begin
                    le_x0_valid = 1'b1;
                    next_state  = LINE_Y0;
                end
                LINE_Y0: begin
                    le_y0_valid = 1'b1;
                    next_ptr    = ptr_q + 4;
                    next_state  = LINE_X1;
                end
                LINE_X1: begin
                    le_x1_valid = 1'b1;
                    next_state  = LINE_Y1;
                end
                LINE_Y1: begin
                    le_y1_valid = 1'b1;
                    le_trigger  = 1'b1;
                    next_ptr    = ptr_q + 4;
                    next_state  = DECODE;
                end
                default: next_state = state;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= IDLE;
            ptr_q   <= '0;
            frame_q <= '0;
        end else begin
            state <= next_state;
            ptr_q <= next_ptr;
            if (gp_valid) begin
                frame_q <= gp_frame;
            end
        end
    end

endmodule

`default_nettype wire

//--- hw/graphics_processor.sv
`timescale 1ns/1ps
`default_nettype none

module graphics_processor
    import gp_cmd_pkg::*;
    import gp_mem_pkg::*;
#(
    parameter int COORD_WIDTH = 10
) (
    input  wire logic                       clk,
    input  wire logic                       rst,

    // host
    input  wire logic                       gp_valid,
    input  wire logic [CMD_WORD_WIDTH-1:0]  gp_code,
    input  wire logic [31:0]                gp_frame,

    // line engine
    input  wire logic                       le_ready,
    output logic [COLOR_WIDTH-1:0]          le_color,
    output logic [COORD_WIDTH-1:0]          le_point,
    output logic                            le_color_valid,
    output logic                            le_x0_valid,
    output logic                            le_y0_valid,
    output logic                            le_x1_valid,
    output logic                            le_y1_valid,
    output logic                            le_trigger,
    output logic [31:0]                     le_frame,

    // frame filler
    input  wire logic                       ff_ready,
    output logic                            ff_valid,
    output logic [COLOR_WIDTH-1:0]          ff_color,
    output logic [31:0]                     ff_frame,

    // DRAM address and read-data FIFOs
    input  wire logic                       af_full,
    output logic                            af_wr_en,
    output logic [DRAM_ADDR_WIDTH-1:0]      af_addr_din,
    input  wire logic                       rdf_valid,
    input  wire logic [BEAT_WIDTH-1:0]      rdf_dout,
    output logic                            rdf_rd_en
);

    line_fill_if fill_bus ();
    cmd_word_if  cmd_bus ();

    dram_line_fetcher u_fetcher (
        .clk         (clk),
        .rst         (rst),
        .fill        (fill_bus.fetcher),
        .af_full     (af_full),
        .af_wr_en    (af_wr_en),
        .af_addr_din (af_addr_din),
        .rdf_valid   (rdf_valid),
        .rdf_dout    (rdf_dout),
        .rdf_rd_en   (rdf_rd_en)
    );

    command_line_buffer u_buffer (
        .clk  (clk),
        .rst  (rst),
        .fill (fill_bus.buffer),
        .cmd  (cmd_bus.buffer)
    );

    command_decoder #(
        .COORD_WIDTH (COORD_WIDTH)
    ) u_decoder (
        .clk            (clk),
        .rst            (rst),
        .cmd            (cmd_bus.decoder),
        .gp_valid       (gp_valid),
        .gp_code        (gp_code),
        .gp_frame       (gp_frame),
        .le_ready       (le_ready),
        .le_color       (le_color),
        .le_point       (le_point),
        .le_color_valid (le_color_valid),
        .le_x0_valid    (le_x0_valid),
        .le_y0_valid    (le_y0_valid),
        .le_x1_valid    (le_x1_valid),
        .le_y1_valid    (le_y1_valid),
        .le_trigger     (le_trigger),
        .le_frame       (le_frame),
        .ff_ready       (ff_ready),
        .ff_valid       (ff_valid),
        .ff_color       (ff_color),
        .ff_frame       (ff_frame)
    );

endmodule

`default_nettype wire

//--- sim/tb_graphics_processor.sv
`timescale 1ns/1ps
`default_nettype none

module tb_graphics_processor
    import gp_cmd_pkg::*;
    import gp_mem_pkg::*;
;

    localparam int COORD_W     = 10;
    localparam int MEM_WORDS   = 256;
    localparam int TEST_WORDS  = 512;
    localparam int DRIVE_DELAY = 2;
    localparam int EV_LINE     = 1;
    localparam int EV_FILL     = 2;

    logic                       clk;
    logic                       rst;
    logic                       gp_valid;
    logic [31:0]                gp_code;
    logic [31:0]                gp_frame;
    logic                       le_ready;
    logic [COLOR_WIDTH-1:0]     le_color;
    logic [COORD_W-1:0]         le_point;
    logic                       le_color_valid;
    logic                       le_x0_valid;
    logic                       le_y0_valid;
    logic                       le_x1_valid;
    logic                       le_y1_valid;
    logic                       le_trigger;
    logic [31:0]                le_frame;
    logic                       ff_ready;
    logic                       ff_valid;
    logic [COLOR_WIDTH-1:0]     ff_color;
    logic [31:0]                ff_frame;
    logic                       af_full;
    logic                       af_wr_en;
    logic [DRAM_ADDR_WIDTH-1:0] af_addr_din;
    logic                       rdf_valid;
    logic [BEAT_WIDTH-1:0]      rdf_dout;
    logic                       rdf_rd_en;

    // command memory seen by the DRAM model, word addressed
    logic [31:0] mem [0:MEM_WORDS-1];
    logic [31:0] tests [0:TEST_WORDS-1];
    logic [31:0] exp_q [$];
    logic [31:0] req_exp_q [$];
    logic [31:0] req_q [$];

    logic [31:0]            test_name;
    logic [31:0]            cur_frame;
    logic                   running;
    logic [31:0]            lfsr_q;
    logic [31:0]            ev_val;
    logic [COLOR_WIDTH-1:0] got_color;
    logic [COORD_W-1:0]     got_x0;
    logic [COORD_W-1:0]     got_y0;
    logic [COORD_W-1:0]     got_x1;
    int                     line_step = 0;
    int                     cycle_count = 0;
    int                     start_cycle;
    int                     cycle_limit;

    graphics_processor #(
        .COORD_WIDTH (COORD_W)
    ) dut (
        .clk (clk), .rst (rst),
        .gp_valid (gp_valid), .gp_code (gp_code), .gp_frame (gp_frame),
        .le_ready (le_ready), .le_color (le_color), .le_point (le_point),
        .le_color_valid (le_color_valid), .le_x0_valid (le_x0_valid),
        .le_y0_valid (le_y0_valid), .le_x1_valid (le_x1_valid),
        .le_y1_valid (le_y1_valid), .le_trigger (le_trigger), .le_frame (le_frame),
        .ff_ready (ff_ready), .ff_valid (ff_valid), .ff_color (ff_color),
        .ff_frame (ff_frame),
        .af_full (af_full), .af_wr_en (af_wr_en), .af_addr_din (af_addr_din),
        .rdf_valid (rdf_valid), .rdf_dout (rdf_dout), .rdf_rd_en (rdf_rd_en)
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;

    task automatic stop_failed();
        $display("TESTBENCH FAILED");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic fail_with(input string why);
        $display("Error in test %s: %s", test_name, why);
        stop_failed();
    endtask

    task automatic compare_value(input string what, input logic [31:0] expected,
                                 input logic [31:0] actual);
        if (expected !== actual) begin
            $display("Mismatch in test %s: %s expected %h actual %h",
                     test_name, what, expected, actual);
            stop_failed();
        end
    endtask

    task automatic next_expected(output logic [31:0] v);
        if (exp_q.size() == 0) begin
            fail_with("DUT produced an event that the test does not expect");
        end else begin
            v = exp_q.pop_front();
        end
    endtask

    // Galois form with maximal length taps
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'hd000_0001) : (s >> 1);
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_next(lfsr_q);
            v = {v[30:0], lfsr_q[0]};
        end
    endtask

    // lowest-addressed word of the beat in bits 31..0
    function automatic logic [BEAT_WIDTH-1:0] dram_beat(input int line, input int beat);
        logic [BEAT_WIDTH-1:0] v;
        for (int k = 0; k < 4; k++) begin
            v[k * 32 +: 32] = mem[line * 8 + beat * 4 + k];
        end
        return v;
    endfunction

    // DRAM, line engine and frame filler models
    initial begin
        logic        accept;
        logic        taken;
        logic        line_pending;
        logic [30:0] req_addr;
        logic [31:0] r;
        int          line_idx;
        int          beat;
        int          delay;
        af_full      = 1'b0;
        rdf_valid    = 1'b0;
        rdf_dout     = '0;
        le_ready     = 1'b0;
        ff_ready     = 1'b0;
        lfsr_q       = 32'h6e3b_4e33;
        line_pending = 1'b0;
        line_idx     = 0;
        beat         = 0;
        delay        = 0;
        forever begin
            @(negedge clk);
            accept   = af_wr_en && !af_full;
            taken    = rdf_rd_en && rdf_valid;
            req_addr = af_addr_din;
            @(posedge clk);
            #DRIVE_DELAY;
            if (accept && line_pending) begin
                fail_with("second line request while a fill is outstanding");
            end else if (accept) begin
                compare_value("address bits outside the tag", 0,
                              {req_addr[30:25], req_addr[1:0]});
                line_idx = int'(req_addr[24:2]);
                if (line_idx >= MEM_WORDS / 8) begin
                    fail_with("line request beyond the end of the command memory");
                end
                req_q.push_back(32'(req_addr));
                line_pending = 1'b1;
                beat         = 0;
                take_bits(2, r);
                delay = int'(r);
            end
            if (taken) begin
                rdf_valid = 1'b0;
                if (beat == 1) begin
                    line_pending = 1'b0;
                end
                beat = 1;
                take_bits(2, r);
                delay = int'(r);
            end
            if (line_pending && !rdf_valid) begin
                if (delay == 0) begin
                    rdf_valid = 1'b1;
                    rdf_dout  = dram_beat(line_idx, beat);
                end else begin
                    delay--;
                end
            end
            take_bits(2, r);
            af_full = (r == 3);
            take_bits(2, r);
            le_ready = (r != 0);
            take_bits(2, r);
            ff_ready = (r != 0);
        end
    end

    // event monitor samples settled outputs at the falling edge
    always @(negedge clk) begin
        if (!rst && !running) begin
            if (le_color_valid || le_x0_valid || le_y0_valid || le_x1_valid ||
                le_y1_valid || le_trigger || ff_valid || af_wr_en || rdf_rd_en) begin
                fail_with("DUT output active while no list is running");
            end
        end else if (!rst) begin
            compare_value("le_frame", cur_frame, le_frame);
            compare_value("ff_frame", cur_frame, ff_frame);
            if (le_color_valid && !le_ready) begin
                fail_with("line color strobe while le_ready is low");
            end
            if (ff_valid && !ff_ready) begin
                fail_with("ff_valid while ff_ready is low");
            end
            if (le_trigger && !le_y1_valid) begin
                fail_with("le_trigger without le_y1_valid");
            end
            if (ff_valid) begin
                compare_value("fill inside a line", 0, line_step);
                next_expected(ev_val);
                compare_value("event kind", ev_val, EV_FILL);
                next_expected(ev_val);
                compare_value("fill color", ev_val, ff_color);
            end
            if (le_color_valid) begin
                compare_value("line step at color", 0, line_step);
                got_color = le_color;
                line_step = 1;
            end
            if (le_x0_valid) begin
                compare_value("line step at x0", 1, line_step);
                got_x0    = le_point;
                line_step = 2;
            end
            if (le_y0_valid) begin
                compare_value("line step at y0", 2, line_step);
                got_y0    = le_point;
                line_step = 3;
            end
            if (le_x1_valid) begin
                compare_value("line step at x1", 3, line_step);
                got_x1    = le_point;
                line_step = 4;
            end
            if (le_y1_valid) begin
                compare_value("line step at y1", 4, line_step);
                compare_value("le_trigger at y1", 1, le_trigger);
                line_step = 0;
                next_expected(ev_val);
                compare_value("event kind", ev_val, EV_LINE);
                next_expected(ev_val);
                compare_value("line color", ev_val, got_color);
                next_expected(ev_val);
                compare_value("line x0", ev_val, got_x0);
                next_expected(ev_val);
                compare_value("line y0", ev_val, got_y0);
                next_expected(ev_val);
                compare_value("line x1", ev_val, got_x1);
                next_expected(ev_val);
                compare_value("line y1", ev_val, le_point);
            end
        end
    end

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count - start_cycle > cycle_limit) begin
            fail_with($sformatf("timeout, test not finished within %0d cycles", cycle_limit));
        end
    end

    initial begin
        logic [31:0] start_addr;
        logic [31:0] frame;
        int          pos;
        int          base;
        int          count;
        int          n_req;
        int          n_events;
        int          n_fields;
        rst         = 1'b1;
        gp_valid    = 1'b0;
        gp_code     = '0;
        gp_frame    = '0;
        running     = 1'b0;
        cur_frame   = '0;
        test_name   = "RST ";
        start_cycle = 0;
        cycle_limit = 200;
        $readmemh("sim/gp_tests.mem", tests);
        repeat (2) @(posedge clk);
        #DRIVE_DELAY;
        rst = 1'b0;
        pos = 0;
        while (tests[pos] !== 32'h0) begin
            if ($isunknown(tests[pos])) begin
                fail_with("test data ends without the end marker");
            end
            test_name  = tests[pos];
            start_addr = tests[pos + 1];
            frame      = tests[pos + 2];
            base       = int'(tests[pos + 3]);
            count      = int'(tests[pos + 4]);
            pos += 5;
            // unloaded words read as an unknown opcode
            for (int i = 0; i < MEM_WORDS; i++) begin
                mem[i] = {8'hee, 24'(i)};
            end
            for (int i = 0; i < count; i++) begin
                mem[base + i] = tests[pos + i];
            end
            pos += count;
            n_req = int'(tests[pos]);
            pos++;
            req_exp_q.delete();
            req_q.delete();
            for (int i = 0; i < n_req; i++) begin
                req_exp_q.push_back(tests[pos + i]);
            end
            pos += n_req;
            n_events = int'(tests[pos]);
            pos++;
            exp_q.delete();
            for (int e = 0; e < n_events; e++) begin
                n_fields = (tests[pos] == EV_LINE) ? 5 : 1;
                for (int j = 0; j <= n_fields; j++) begin
                    exp_q.push_back(tests[pos + j]);
                end
                pos += n_fields + 1;
            end
            start_cycle = cycle_count;
            cycle_limit = 60 * count + 200;

            @(posedge clk);
            #DRIVE_DELAY;
            gp_valid = 1'b1;
            gp_code  = start_addr;
            gp_frame = frame;
            @(posedge clk);
            #DRIVE_DELAY;
            gp_valid  = 1'b0;
            cur_frame = frame;
            running   = 1'b1;

            // list is over once the decoder is idle with no fill pending
            do begin
                @(posedge clk);
                #DRIVE_DELAY;
            end while (exp_q.size() != 0 || dut.u_decoder.state != IDLE ||
                       dut.fill_bus.fill_req);
            // quiet window catches late events and requests
            repeat (10) @(posedge clk);
            #DRIVE_DELAY;
            compare_value("line request count", req_exp_q.size(), req_q.size());
            for (int i = 0; i < req_exp_q.size(); i++) begin
                compare_value("line request address", req_exp_q[i], req_q[i]);
            end
            running = 1'b0;
        end
        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- sim/gp_tests.mem
// per test: name (4 ASCII chars), start byte address, frame address
// image word base and word count, then the image words
// request count and af_addr_din values, event count, then the events
// event: 00000001 color x0 y0 x1 y1 for LINE, 00000002 color for FILL
// single LINE then END
4c494e31 00000040 00100000
00000010 00000004
01ff0000 00100020 01230045 00000000
00000001 00000008
00000001
00000001 00ff0000 00000010 00000020 00000123 00000045
// FILL and LINE mixed in one line
4d495832 00000100 00200000
00000040 00000006
02123456 01abcdef 01550066 00030004 02000fff 00000000
00000001 00000020
00000003
00000002 00123456
00000001 00abcdef 00000155 00000066 00000003 00000004
00000002 00000fff
// LINE split across the line 4 / line 5 boundary
58424e44 00000094 00300000
00000025 00000006
02a0a0a0 01b1b1b1 00110022 00330044 02c2c2c2 00000000
00000002 00000010 00000014
00000003
00000002 00a0a0a0
00000001 00b1b1b1 00000011 00000022 00000033 00000044
00000002 00c2c2c2
// same line run twice with a new image in between
52554e41 00000200 00400000
00000080 00000002
02111111 00000000
00000001 00000040
00000001
00000002 00111111
52554e42 00000200 00500000
00000080 00000005
01222222 01000200 03ff0001 02333333 00000000
00000001 00000040
00000002
00000001 00222222 00000100 00000200 000003ff 00000001
00000002 00333333
// unknown opcode stops the list
554e4b4e 000002f0 00600000
000000bc 00000004
02444444 7f000000 02555555 01666666
00000001 0000005c
00000001
00000002 00444444
// end marker
00000000

//--- filelist.f
hw/gp_cmd_pkg.sv
hw/gp_mem_pkg.sv
hw/line_fill_if.sv
hw/cmd_word_if.sv
hw/dram_line_fetcher.sv
hw/command_line_buffer.sv
hw/command_decoder.sv
hw/graphics_processor.sv
sim/tb_graphics_processor.sv
